// File: build.f
+incdir+common
common/audio_pkg.sv
verilog/port_decode.sv
verilog/sound_regs.sv
audio/audio_mixer.sv
audio/audio_compressor.sv
verilog/audio_top.sv
verification/tb_audio_top.sv

// File: Makefile
# verilator flow for the audio back end
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_audio_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK

.PHONY: all lint build sim clean

all: sim

# static checks on rtl and testbench together
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# compile the testbench into a simulation binary
build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# run, keep the log, then judge the log
sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_audio_top.sv
`timescale 1ns/10ps
`include "audio_consts.svh"
`default_nettype none

module tb_audio_top;

  // a port write needs three edges to reach audio_out
  localparam int settle_cycles = 5;
  localparam int reset_timeout = 64;
  localparam int random_rounds = 20;

  logic        clk_28mhz = 1'b0;
  logic        rst;
  logic [15:0] cpu_addr;
  logic [7:0]  cpu_dout;
  logic        iorq_n;
  logic        wr_n;
  logic [11:0] ts_l;
  logic [11:0] ts_r;
  logic [7:0]  saa_l;
  logic [7:0]  saa_r;
  logic        ts_we;
  logic        ts_bc;
  logic        saa_wr_n;
  logic [15:0] audio_out_l;
  logic [15:0] audio_out_r;

  // what the two dut registers should hold
  logic [7:0]  model_covox;
  logic        model_beep;

  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  bit          released;

  // 8 ns period
  always #4 clk_28mhz = ~clk_28mhz;

  audio_top u_dut (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .cpu_addr    (cpu_addr),
    .cpu_dout    (cpu_dout),
    .iorq_n      (iorq_n),
    .wr_n        (wr_n),
    .ts_l        (ts_l),
    .ts_r        (ts_r),
    .saa_l       (saa_l),
    .saa_r       (saa_r),
    .ts_we       (ts_we),
    .ts_bc       (ts_bc),
    .saa_wr_n    (saa_wr_n),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r)
  );

  // reference model of the shifted sum mod 2^16 and the two-slope curve
  function automatic logic [15:0] expected_out(input logic [11:0] ts, input logic [7:0] saa,
                                               input logic [7:0] cov, input logic beep);
    int   sum;
    int   mag;
    int   res;
    logic neg;
    sum = (int'(ts) << `TS_SHIFT) + ((int'(saa) + int'(cov) + int'(beep)) << `CHIP_SHIFT);
    sum = sum % 65536;
    // upper half of the 16-bit range is negative
    neg = (sum >= 32768);
    mag = neg ? 65536 - sum : sum;
    if (mag < `COMP_X) begin
      res = mag * `COMP_A;
    end else begin
      res = (mag - `COMP_X) / `COMP_F + `COMP_B;
    end
    if (neg) begin
      res = (65536 - res) % 65536;
    end
    return 16'(res);
  endfunction

  // wait for rst low at a falling edge within reset_timeout cycles
  task automatic wait_reset_release(output bit ok);
    int cyc;
    ok = 1'b0;
    for (cyc = 0; cyc < reset_timeout && !ok; cyc++) begin
      @(negedge clk_28mhz);
      if (rst == 1'b0) begin
        ok = 1'b1;
      end
    end
  endtask

  // new chip samples on the next rising edge
  task automatic drive_sources(input logic [11:0] tl, input logic [11:0] tr,
                               input logic [7:0] sl, input logic [7:0] sr);
    @(posedge clk_28mhz);
    ts_l  <= tl;
    ts_r  <= tr;
    saa_l <= sl;
    saa_r <= sr;
  endtask

  // one-clock i/o write or read cycle
  task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input bit is_write);
    @(posedge clk_28mhz);
    cpu_addr <= addr;
    cpu_dout <= data;
    iorq_n   <= 1'b0;
    wr_n     <= ~is_write;
    @(posedge clk_28mhz);
    iorq_n   <= 1'b1;
    wr_n     <= 1'b1;
  endtask

  // both sides against the model once the pipeline has settled
  task automatic compare_audio(input string label);
    int          cyc;
    logic [15:0] exp_l;
    logic [15:0] exp_r;
    for (cyc = 0; cyc < settle_cycles; cyc++) begin
      @(negedge clk_28mhz);
    end
    exp_l = expected_out(ts_l, saa_l, model_covox, model_beep);
    exp_r = expected_out(ts_r, saa_r, model_covox, model_beep);
    if (audio_out_l !== exp_l) begin
      $display("mismatch at %0t: %s left got %h expected %h",
               $time, label, audio_out_l, exp_l);
      test_errors++;
    end
    if (audio_out_r !== exp_r) begin
      $display("mismatch at %0t: %s right got %h expected %h",
               $time, label, audio_out_r, exp_r);
      test_errors++;
    end
  endtask

  // combinational strobes sampled mid-cycle while the bus is driven
  task automatic probe_strobes(input logic [15:0] addr, input bit is_write,
                               input logic exp_we, input logic exp_saa_n);
    @(posedge clk_28mhz);
    cpu_addr <= addr;
    cpu_dout <= 8'h00;
    iorq_n   <= 1'b0;
    wr_n     <= ~is_write;
    @(negedge clk_28mhz);
    if (ts_we !== exp_we || saa_wr_n !== exp_saa_n || ts_bc !== addr[14]) begin
      $display("mismatch at %0t: addr %h wr %0d got we/saa_n/bc %b%b%b expected %b%b%b",
               $time, addr, is_write, ts_we, saa_wr_n, ts_bc, exp_we, exp_saa_n, addr[14]);
      test_errors++;
    end
    @(posedge clk_28mhz);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  // idle bus and silent sources after reset
  task automatic reset_state();
    int cyc;
    for (cyc = 0; cyc < settle_cycles; cyc++) begin
      @(negedge clk_28mhz);
      if (audio_out_l !== 16'h0000 || audio_out_r !== 16'h0000) begin
        $display("mismatch at %0t: audio not silent after reset, %h %h",
                 $time, audio_out_l, audio_out_r);
        test_errors++;
      end
      if (ts_we !== 1'b0 || saa_wr_n !== 1'b1) begin
        $display("mismatch at %0t: strobes active on idle bus, we %b saa_n %b",
                 $time, ts_we, saa_wr_n);
        test_errors++;
      end
    end
    close_test("reset_state");
  endtask

  // samples below and above the knee with both signs
  task automatic ts_path();
    drive_sources(12'h100, 12'h500, 8'h00, 8'h00);
    compare_audio("ts below/above knee");
    drive_sources(12'hC00, 12'hF80, 8'h00, 8'h00);
    compare_audio("ts negative");
    drive_sources(12'h36D, 12'h36E, 8'h00, 8'h00);
    compare_audio("ts at knee");
    drive_sources(12'h800, 12'hFFF, 8'h00, 8'h00);
    compare_audio("ts extremes");
    close_test("ts_path");
  endtask

  task automatic saa_and_covox();
    drive_sources(12'h000, 12'h000, 8'h40, 8'hC3);
    compare_audio("saa only");
    bus_cycle({8'h12, `PORT_COVOX}, 8'h5A, 1'b1);
    model_covox = 8'h5A;
    compare_audio("saa plus covox");
    close_test("saa_and_covox");
  endtask

  task automatic beeper_and_isolation();
    drive_sources(12'h120, 12'h0F0, 8'h10, 8'h20);
    bus_cycle({8'h00, `PORT_FE}, 8'h10, 1'b1);
    model_beep = 1'b1;
    compare_audio("beeper on");
    // other low bytes and the ts window must not touch the registers
    bus_cycle(16'h00FA, 8'h00, 1'b1);
    bus_cycle(16'h00FC, 8'h00, 1'b1);
    bus_cycle(16'h00FF, 8'h00, 1'b1);
    bus_cycle(16'hBFFD, 8'h00, 1'b1);
    // reads of the real ports neither
    bus_cycle({8'h00, `PORT_FE}, 8'h00, 1'b0);
    bus_cycle({8'h00, `PORT_COVOX}, 8'h00, 1'b0);
    compare_audio("registers held");
    bus_cycle({8'h7F, `PORT_FE}, 8'hEF, 1'b1);
    model_beep = 1'b0;
    compare_audio("beeper off");
    close_test("beeper_and_isolation");
  endtask

  task automatic external_strobes();
    // ts window
    probe_strobes(16'h80FD, 1'b1, 1'b1, 1'b1);
    probe_strobes(16'hC0FD, 1'b1, 1'b1, 1'b1);
    probe_strobes(16'h8001, 1'b1, 1'b1, 1'b1);
    // one ts address bit wrong
    probe_strobes(16'h0001, 1'b1, 1'b0, 1'b1);
    probe_strobes(16'h8003, 1'b1, 1'b0, 1'b1);
    probe_strobes(16'h8000, 1'b1, 1'b0, 1'b1);
    // saa at low byte ff with any high byte
    probe_strobes(16'h00FF, 1'b1, 1'b0, 1'b0);
    probe_strobes(16'hFFFF, 1'b1, 1'b0, 1'b0);
    // reads never strobe
    probe_strobes(16'h80FD, 1'b0, 1'b0, 1'b1);
    probe_strobes(16'h00FF, 1'b0, 1'b0, 1'b1);
    close_test("external_strobes");
  endtask

  task automatic random_mix();
    int         i;
    int         kind;
    logic [7:0] data;
    logic [7:0] high;
    for (i = 0; i < random_rounds; i++) begin
      drive_sources(12'($urandom), 12'($urandom), 8'($urandom), 8'($urandom));
      kind = int'($urandom % 4);
      data = 8'($urandom);
      high = 8'($urandom);
      case (kind)
        0: begin
          bus_cycle({high, `PORT_FE}, data, 1'b1);
          model_beep = data[`BEEPER_BIT];
        end
        1: begin
          bus_cycle({high, `PORT_COVOX}, data, 1'b1);
          model_covox = data;
        end
        2: begin
          // unused port leaves the registers alone
          bus_cycle({high, 8'hF7}, data, 1'b1);
        end
        default: begin
          bus_cycle({high, `PORT_COVOX}, data, 1'b0);
        end
      endcase
      compare_audio($sformatf("random round %0d", i));
    end
    close_test("random_mix");
  endtask

  // reset held for 16 rising edges
  initial begin
    rst <= 1'b1;
    repeat (16) @(posedge clk_28mhz);
    rst <= 1'b0;
  end

  initial begin
    void'($urandom(32'he5e1));
    cpu_addr <= 16'h0000;
    cpu_dout <= 8'h00;
    iorq_n   <= 1'b1;
    wr_n     <= 1'b1;
    ts_l     <= 12'h000;
    ts_r     <= 12'h000;
    saa_l    <= 8'h00;
    saa_r    <= 8'h00;
    model_covox = 8'h00;
    model_beep  = 1'b0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    wait_reset_release(released);
    if (!released) begin
      $display("reset was not released within %0d cycles", reset_timeout);
      $display("TEST FAILED");
      $finish;
    end else begin
      reset_state();
      ts_path();
      saa_and_covox();
      beeper_and_isolation();
      external_strobes();
      random_mix();
      $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
               tests_run, tests_run - tests_failed, tests_failed, total_errors);
      if (tests_failed == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule : tb_audio_top

`default_nettype wire

// File: verilog/audio_top.sv
`timescale 1ns/10ps
`default_nettype none

module audio_top
  import audio_pkg::*;
(
  input  wire               clk_28mhz,
  input  wire               rst,
  // z80 bus
  input  wire [15:0]        cpu_addr,
  input  wire [7:0]         cpu_dout,
  input  wire               iorq_n,
  input  wire               wr_n,
  // samples from the external chips
  input  wire ts_sample_t   ts_l,
  input  wire ts_sample_t   ts_r,
  input  wire chip_sample_t saa_l,
  input  wire chip_sample_t saa_r,
  // strobes to the external chips
  output wire               ts_we,
  output wire               ts_bc,
  output wire               saa_wr_n,
  // compressed stereo out
  output wire mix_sample_t  audio_out_l,
  output wire mix_sample_t  audio_out_r
);

  logic         io_write;
  io_port_t     io_port;
  logic         beeper;
  chip_sample_t covox;
  mix_sample_t  pre_l;
  mix_sample_t  pre_r;

  // ay bc1 is a14, ts chip select and register/data pick
  assign ts_bc = cpu_addr[14];

  // decode, no clock
  port_decode u_port_decode (
    .cpu_addr (cpu_addr),
    .iorq_n   (iorq_n),
    .wr_n     (wr_n),
    .io_write (io_write),
    .io_port  (io_port),
    .ts_we    (ts_we),
    .saa_wr_n (saa_wr_n)
  );

  // #FE and covox registers
  sound_regs u_sound_regs (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .io_write  (io_write),
    .io_port   (io_port),
    .cpu_dout  (cpu_dout),
    .beeper    (beeper),
    .covox     (covox)
  );

  // first stage, sum of all sources
  audio_mixer u_audio_mixer (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .ts_l      (ts_l),
    .ts_r      (ts_r),
    .saa_l     (saa_l),
    .saa_r     (saa_r),
    .covox     (covox),
    .beeper    (beeper),
    .pre_l     (pre_l),
    .pre_r     (pre_r)
  );

  // second stage, soft compression
  audio_compressor u_audio_compressor (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .pre_l       (pre_l),
    .pre_r       (pre_r),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r)
  );

endmodule : audio_top

`default_nettype wire

// File: audio/audio_compressor.sv
`timescale 1ns/10ps
`include "audio_consts.svh"
`default_nettype none

module audio_compressor
  import audio_pkg::*;
(
  input  wire              clk_28mhz,
  input  wire              rst,
  // pre-mix from the mixer, two's complement
  input  wire mix_sample_t pre_l,
  input  wire mix_sample_t pre_r,
  // final stereo pair
  output mix_sample_t      audio_out_l,
  output mix_sample_t      audio_out_r
);

  // two-slope curve on the magnitude, sign put back at the end
  //   below the knee: gain COMP_A
  //   above the knee: 1/COMP_F, starting at COMP_B
  function automatic mix_sample_t compress(input mix_sample_t x);
    mix_sample_t mag;
    mix_sample_t res;

    // bit 15 is the sign
    mag = x[15] ? -x : x;

    if (mag < 16'(`COMP_X)) begin
      // quiet part gets boosted
      res = mag * 16'(`COMP_A);
    end else begin
      // loud part flattened, remainder dropped
      res = ((mag - 16'(`COMP_X)) / 16'(`COMP_F)) + 16'(`COMP_B);
    end

    return x[15] ? -res : res;
  endfunction

  // same curve on both sides, one clock
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else begin
      audio_out_l <= compress(pre_l);
      audio_out_r <= compress(pre_r);
    end
  end

  // sign survives the curve
  // pre-mix moves in steps of 16, so only -32768 can spill
  // past the 16-bit range and is left out of the check
  assert property (@(posedge clk_28mhz) disable iff (rst)
    (pre_l != '0 && pre_l != 16'h8000)
    |=> audio_out_l[15] == $past(pre_l[15]))
    else $error("audio_compressor: left sign flipped");

  assert property (@(posedge clk_28mhz) disable iff (rst)
    (pre_r != '0 && pre_r != 16'h8000)
    |=> audio_out_r[15] == $past(pre_r[15]))
    else $error("audio_compressor: right sign flipped");

endmodule : audio_compressor

`default_nettype wire

// File: audio/audio_mixer.sv
`timescale 1ns/10ps
`include "audio_consts.svh"
`default_nettype none

module audio_mixer
  import audio_pkg::*;
(
  input  wire               clk_28mhz,
  input  wire               rst,
  // turbosound, left and right
  input  wire ts_sample_t   ts_l,
  input  wire ts_sample_t   ts_r,
  // saa1099, left and right
  input  wire chip_sample_t saa_l,
  input  wire chip_sample_t saa_r,
  // mono sources, fed to both sides
  input  wire chip_sample_t covox,
  input  wire               beeper,
  // pre-mix to the compressor
  output mix_sample_t       pre_l,
  output mix_sample_t       pre_r
);

  mix_sample_t ts_l_al;
  mix_sample_t ts_r_al;
  mix_sample_t saa_l_al;
  mix_sample_t saa_r_al;
  mix_sample_t covox_al;
  mix_sample_t beep_al;
  mix_sample_t mono_al;

  // turbosound scaled to the top of the word
  assign ts_l_al = mix_sample_t'(ts_l) << `TS_SHIFT;
  assign ts_r_al = mix_sample_t'(ts_r) << `TS_SHIFT;

  // 8-bit chips two bits down from full scale
  assign saa_l_al = mix_sample_t'(saa_l) << `CHIP_SHIFT;
  assign saa_r_al = mix_sample_t'(saa_r) << `CHIP_SHIFT;

  // covox and beeper are mono
  assign covox_al = mix_sample_t'(covox) << `CHIP_SHIFT;
  // beeper is one lsb of the chip scale
  assign beep_al = mix_sample_t'(beeper) << `CHIP_SHIFT;
  // summed once, shared by both sides
  assign mono_al = covox_al + beep_al;

  // one registered add per side
  // no saturation, the sum wraps at 16 bits
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      pre_l <= '0;
      pre_r <= '0;
    end else begin
      pre_l <= ts_l_al + saa_l_al + mono_al;
      pre_r <= ts_r_al + saa_r_al + mono_al;
    end
  end

endmodule : audio_mixer

`default_nettype wire

// File: verilog/sound_regs.sv
`timescale 1ns/10ps
`include "audio_consts.svh"
`default_nettype none

module sound_regs
  import audio_pkg::*;
(
  input  wire                clk_28mhz,
  input  wire                rst,
  // decoded write from port_decode
  input  wire                io_write,
  input  wire io_port_t      io_port,
  input  wire [7:0]          cpu_dout,
  // to the mixer
  output logic               beeper,
  output chip_sample_t       covox
);

  // full #FE register
  // border bits live here too, only the beeper leaves
  logic [7:0] fe_reg;

  // a long write just reloads the same value each clock
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_reg <= '0;
      covox  <= '0;
    end else if (io_write) begin
      case (io_port)
        port_fe: begin
          fe_reg <= cpu_dout;
        end
        port_covox: begin
          covox <= cpu_dout;
        end
        default: begin
          // ts and saa writes go to the external chips
        end
      endcase
    end
  end

  // speaker bit
  assign beeper = fe_reg[`BEEPER_BIT];

  // silent start, the mixer sees no stale level
  assert property (@(posedge clk_28mhz)
    rst |=> (beeper == 1'b0) && (covox == '0))
    else $error("sound_regs: outputs not cleared after reset");

endmodule : sound_regs

`default_nettype wire

// File: verilog/port_decode.sv
`timescale 1ns/10ps
`include "audio_consts.svh"
`default_nettype none

module port_decode
  import audio_pkg::*;
(
  // z80 bus, write side only
  input  wire [15:0] cpu_addr,
  input  wire        iorq_n,
  input  wire        wr_n,
  // decoded write cycle
  output logic       io_write,
  output io_port_t   io_port,
  // strobes for the external sound chips
  output logic       ts_we,
  output logic       saa_wr_n
);

  logic [7:0] low_byte;
  logic       ts_hit;

  // spectrum style partial decode, only the low byte counts
  assign low_byte = cpu_addr[7:0];

  // turbosound window
  // a15 high, a1 low, a0 high
  assign ts_hit = cpu_addr[15] & ~cpu_addr[1] & cpu_addr[0];

  // z80 i/o write, can span several clocks
  assign io_write = ~iorq_n & ~wr_n;

  // port kind, turbosound checked first
  always_comb begin
    if (ts_hit) begin
      io_port = port_ts;
    end else if (low_byte == `PORT_FE) begin
      io_port = port_fe;
    end else if (low_byte == `PORT_COVOX) begin
      io_port = port_covox;
    end else if (low_byte == `PORT_SAA) begin
      io_port = port_saa;
    end else begin
      io_port = port_none;
    end
  end

  // level strobes, follow the bus with no delay
  always_comb begin
    // ay bdir, bc comes straight from a14 at the top
    ts_we = io_write & (io_port == port_ts);
    // saa wants an active low write
    saa_wr_n = ~(io_write & (io_port == port_saa));

    // the two chips share the data bus
    // never let both latch the same write
    assert (!(ts_we && !saa_wr_n))
      else $error("port_decode: ts_we and saa_wr_n active together");
  end

endmodule : port_decode

`default_nettype wire

// File: common/audio_pkg.sv
`default_nettype none

package audio_pkg;

  // which sound port a z80 i/o write lands on
  // port_none covers every address the audio block ignores
  typedef enum logic [2:0] {
    port_none,
    // border and beeper register
    port_fe,
    // 8-bit covox dac level
    port_covox,
    // turbosound register window
    port_ts,
    // saa1099 address and data writes
    port_saa
  } io_port_t;

  // one turbosound channel, unsigned
  typedef logic [11:0] ts_sample_t;

  // one saa channel or the covox level, unsigned
  typedef logic [7:0] chip_sample_t;

  // pre-mix and compressed output
  // compressor reads bit 15 as the sign
  typedef logic [15:0] mix_sample_t;

endpackage : audio_pkg

`default_nettype wire

// File: common/audio_consts.svh
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// low address byte of each fixed sound port
// border / beeper
`define PORT_FE 8'hFE
// covox dac
`define PORT_COVOX 8'hFB
// saa1099, a8 picks address or data inside the chip
`define PORT_SAA 8'hFF

// left shifts that bring every source onto the 16-bit mix scale
// 12-bit turbosound fills the top of the word
`define TS_SHIFT 4
// saa, covox and beeper sit two bits lower for headroom
`define CHIP_SHIFT 6

// bit of the #FE register that drives the speaker
`define BEEPER_BIT 4

// two-slope soft compressor
// slope above the knee is 1/COMP_F
`define COMP_F 4
// slope below the knee
`define COMP_A 2
// knee: 32767*(COMP_F-1)/(COMP_F*COMP_A-1) + 1
// the +1 keeps the upper segment from starting above the lower one
`define COMP_X 14044
// output level at the knee, COMP_X*COMP_A
`define COMP_B 28088

`endif
